// ==== list.f ====
+incdir+src
src/axi_bridge_pkg.sv
src/cache_req_latch.sv
src/axi_bridge_ctrl.sv
src/axi_read_port.sv
src/axi_write_port.sv
src/axi_sram_bridge.sv
verification/axi_bridge_assertions.sv
verification/axi_sram_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: axi_sram_bridge

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/axi_bridge_pkg.sv
      - src/cache_req_latch.sv
      - src/axi_bridge_ctrl.sv
      - src/axi_read_port.sv
      - src/axi_write_port.sv
      - src/axi_sram_bridge.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/axi_bridge_assertions.sv
      - verification/axi_sram_bridge_tb.sv

// ==== verification/axi_sram_bridge_tb.sv ====
`timescale 1ns/10ps
`include "axi_bridge_settings.svh"

module axi_sram_bridge_tb;

	localparam int max_wait_cycles = 400;
	localparam logic [`BRIDGE_SIZE_W-1:0] word_size = 3'd2;   // 4 byte beats

	logic                      aclk;
	logic                      aresetn;
	logic                      icache_rd_req;
	logic [`BRIDGE_ADDR_W-1:0] icache_rd_addr;
	logic [`BRIDGE_SIZE_W-1:0] icache_rd_size;
	logic                      icache_rd_rdy;
	logic                      icache_ret_valid;
	logic                      icache_ret_last;
	logic [`BRIDGE_DATA_W-1:0] icache_ret_data;
	logic                      dcache_rd_req;
	logic [`BRIDGE_ADDR_W-1:0] dcache_rd_addr;
	logic [`BRIDGE_SIZE_W-1:0] dcache_rd_size;
	logic                      dcache_rd_uncached;
	logic                      dcache_rd_rdy;
	logic                      dcache_ret_valid;
	logic                      dcache_ret_last;
	logic [`BRIDGE_DATA_W-1:0] dcache_ret_data;
	logic                      dcache_wr_req;
	logic [`BRIDGE_ADDR_W-1:0] dcache_wr_addr;
	logic [`BRIDGE_SIZE_W-1:0] dcache_wr_size;
	logic [`BRIDGE_STRB_W-1:0] dcache_wr_strb;
	logic                      dcache_wr_uncached;
	logic [`BRIDGE_LINE_W-1:0] dcache_wr_line;
	logic [`BRIDGE_DATA_W-1:0] dcache_wr_word;
	logic                      dcache_wr_rdy;
	logic [`BRIDGE_ID_W-1:0]   arid;
	logic [`BRIDGE_ADDR_W-1:0] araddr;
	logic [`BRIDGE_LEN_W-1:0]  arlen;
	logic [`BRIDGE_SIZE_W-1:0] arsize;
	logic [1:0]                arburst;
	logic                      arvalid;
	logic                      arready;
	logic [`BRIDGE_DATA_W-1:0] rdata;
	logic                      rlast;
	logic                      rvalid;
	logic                      rready;
	logic [`BRIDGE_ID_W-1:0]   awid;
	logic [`BRIDGE_ADDR_W-1:0] awaddr;
	logic [`BRIDGE_LEN_W-1:0]  awlen;
	logic [`BRIDGE_SIZE_W-1:0] awsize;
	logic [1:0]                awburst;
	logic                      awvalid;
	logic                      awready;
	logic [`BRIDGE_ID_W-1:0]   wid;
	logic [`BRIDGE_DATA_W-1:0] wdata;
	logic [`BRIDGE_STRB_W-1:0] wstrb;
	logic                      wlast;
	logic                      wvalid;
	logic                      wready;
	logic                      bvalid;
	logic                      bready;
	integer                    seed;

	axi_sram_bridge axi_sram_bridge_inst (.*);

	initial begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic report_error(input string msg);
		abort_run($sformatf("Error at %0t ns: %s", $time, msg));
	endtask

	task automatic report_timeout(input string what);
		abort_run($sformatf("Timed out at %0t ns while waiting for %s", $time, what));
	endtask

	// ready with random low stretches when stalling
	function automatic logic rand_ready(input bit stall);
		return stall ? (($random(seed) & 3) != 0) : 1'b1;
	endfunction

	task automatic fill_line(output logic [`BRIDGE_LINE_W-1:0] line);
		for (int i = 0; i < `BRIDGE_LINE_BEATS; i++) begin
			line[i*`BRIDGE_DATA_W +: `BRIDGE_DATA_W] = $random(seed);
		end
	endtask

	task automatic check_reset_state();
		assert (!arvalid && !awvalid && !wvalid && !bready && rready === 1'b1)
		else report_error("AXI valid or ready outputs wrong after reset");
		assert (!icache_ret_valid && !dcache_ret_valid)
		else report_error("return valid high after reset");
		assert (icache_rd_rdy === 1'b1 && dcache_rd_rdy === 1'b1 && dcache_wr_rdy === 1'b1)
		else report_error("rdy outputs not high in idle after reset");
	endtask

	// owner gets the beat and the other cache sees nothing
	task automatic check_ret(input bit to_dcache, input bit exp_valid, input bit exp_last,
		input logic [`BRIDGE_DATA_W-1:0] exp_data);
		logic                      own_valid;
		logic                      own_last;
		logic [`BRIDGE_DATA_W-1:0] own_data;
		logic                      other_busy;
		own_valid  = to_dcache ? dcache_ret_valid : icache_ret_valid;
		own_last   = to_dcache ? dcache_ret_last : icache_ret_last;
		own_data   = to_dcache ? dcache_ret_data : icache_ret_data;
		other_busy = to_dcache ? (icache_ret_valid | icache_ret_last) :
			(dcache_ret_valid | dcache_ret_last);
		assert (other_busy === 1'b0)
		else report_error("read beat routed to the cache that did not ask");
		assert (own_valid === exp_valid && own_last === exp_last)
		else report_error($sformatf("ret valid/last %b/%b, expected %b/%b",
			own_valid, own_last, exp_valid, exp_last));
		if (exp_valid) begin
			assert (own_data === exp_data)
			else report_error($sformatf("ret data %h, expected %h", own_data, exp_data));
		end
	endtask

	task automatic request_read(input bit from_dcache, input logic [`BRIDGE_ADDR_W-1:0] addr,
		input bit uncached);
		int cycles;
		bit accepted;
		if (from_dcache) begin
			dcache_rd_req      <= 1'b1;
			dcache_rd_addr     <= addr;
			dcache_rd_size     <= word_size;
			dcache_rd_uncached <= uncached;
		end else begin
			icache_rd_req  <= 1'b1;
			icache_rd_addr <= addr;
			icache_rd_size <= word_size;
		end
		cycles   = 0;
		accepted = 1'b0;
		while (!accepted) begin
			@(posedge aclk);
			accepted = from_dcache ? dcache_rd_rdy : icache_rd_rdy;
			cycles++;
			if (!accepted && cycles > max_wait_cycles) begin
				report_timeout("read request accept");
			end
		end
		dcache_rd_req <= 1'b0;
		icache_rd_req <= 1'b0;
	endtask

	task automatic request_write(input logic [`BRIDGE_ADDR_W-1:0] addr,
		input logic [`BRIDGE_STRB_W-1:0] strb, input bit uncached,
		input logic [`BRIDGE_LINE_W-1:0] line, input logic [`BRIDGE_DATA_W-1:0] word);
		int cycles;
		cycles = 0;
		dcache_wr_req      <= 1'b1;
		dcache_wr_addr     <= addr;
		dcache_wr_size     <= word_size;
		dcache_wr_strb     <= strb;
		dcache_wr_uncached <= uncached;
		dcache_wr_line     <= line;
		dcache_wr_word     <= word;
		do begin
			@(posedge aclk);
			cycles++;
			if (!dcache_wr_rdy && cycles > max_wait_cycles) begin
				report_timeout("write request accept");
			end
		end while (!dcache_wr_rdy);
		dcache_wr_req <= 1'b0;
	endtask

	// AXI slave read side with beat data at address plus 4 per beat
	task automatic serve_read(input logic [`BRIDGE_ADDR_W-1:0] exp_addr, input bit uncached,
		input bit to_dcache, input bit stall);
		int                      cycles;
		int                      beat;
		int                      last_beat;
		bit                      done;
		logic [`BRIDGE_LEN_W-1:0] exp_len;
		logic [1:0]              exp_burst;
		logic [`BRIDGE_ID_W-1:0] exp_id;
		last_beat = uncached ? 0 : `BRIDGE_LINE_BEATS - 1;
		exp_len   = last_beat;
		exp_burst = uncached ? `BRIDGE_BURST_FIXED : `BRIDGE_BURST_INCR;
		exp_id    = to_dcache ? `BRIDGE_DCACHE_ID : `BRIDGE_ICACHE_ID;
		cycles    = 0;
		done      = 1'b0;
		arready <= rand_ready(stall);
		while (!done) begin
			@(posedge aclk);
			check_ret(to_dcache, 1'b0, 1'b0, '0);
			if (arvalid && arready) begin
				assert (araddr === exp_addr && arlen === exp_len && arsize === word_size &&
					arburst === exp_burst && arid === exp_id)
				else report_error($sformatf(
					"ar addr/len/size/burst/id %h/%0d/%0d/%0d/%0d, expected %h/%0d/%0d/%0d/%0d",
					araddr, arlen, arsize, arburst, arid,
					exp_addr, exp_len, word_size, exp_burst, exp_id));
				done = 1'b1;
				arready <= 1'b0;
			end else begin
				arready <= rand_ready(stall);
				cycles++;
				if (cycles > max_wait_cycles) begin
					report_timeout("arvalid");
				end
			end
		end
		beat = 0;
		rvalid <= 1'b1;
		rdata  <= exp_addr;
		rlast  <= (last_beat == 0);
		while (beat <= last_beat) begin
			@(posedge aclk);
			check_ret(to_dcache, 1'b1, beat == last_beat, exp_addr + 4 * beat);
			beat++;
			rdata <= exp_addr + 4 * beat;
			rlast <= (beat == last_beat);
			if (beat > last_beat) begin
				rvalid <= 1'b0;
				rlast  <= 1'b0;
			end
		end
	endtask

	// AXI slave write side that keeps the write busy until the b handshake
	task automatic serve_write(input logic [`BRIDGE_ADDR_W-1:0] exp_addr,
		input logic [`BRIDGE_STRB_W-1:0] exp_strb, input bit uncached,
		input logic [`BRIDGE_LINE_W-1:0] exp_line, input logic [`BRIDGE_DATA_W-1:0] exp_word,
		input bit stall);
		int                        cycles;
		int                        beat;
		int                        last_beat;
		bit                        done;
		logic [`BRIDGE_DATA_W-1:0] exp_data;
		logic [`BRIDGE_LEN_W-1:0]  exp_len;
		logic [1:0]                exp_burst;
		last_beat = uncached ? 0 : `BRIDGE_LINE_BEATS - 1;
		exp_len   = last_beat;
		exp_burst = uncached ? `BRIDGE_BURST_FIXED : `BRIDGE_BURST_INCR;
		cycles    = 0;
		done      = 1'b0;
		awready <= rand_ready(stall);
		while (!done) begin
			@(posedge aclk);
			assert (dcache_wr_rdy === 1'b0) else report_error("dcache_wr_rdy high in aw phase");
			if (awvalid && awready) begin
				assert (awaddr === exp_addr && awlen === exp_len && awsize === word_size &&
					awburst === exp_burst && awid === `BRIDGE_DCACHE_ID)
				else report_error($sformatf(
					"aw addr/len/size/burst/id %h/%0d/%0d/%0d/%0d, expected %h/%0d/%0d/%0d",
					awaddr, awlen, awsize, awburst, awid,
					exp_addr, exp_len, word_size, exp_burst));
				done = 1'b1;
				awready <= 1'b0;
			end else begin
				awready <= rand_ready(stall);
				cycles++;
				if (cycles > max_wait_cycles) begin
					report_timeout("awvalid");
				end
			end
		end
		beat   = 0;
		cycles = 0;
		wready <= rand_ready(stall);
		while (beat <= last_beat) begin
			@(posedge aclk);
			assert (dcache_wr_rdy === 1'b0) else report_error("dcache_wr_rdy high in w phase");
			if (wvalid && wready) begin
				exp_data = uncached ? exp_word : exp_line[beat*`BRIDGE_DATA_W +: `BRIDGE_DATA_W];
				assert (wdata === exp_data && wstrb === exp_strb && wid === `BRIDGE_DCACHE_ID)
				else report_error($sformatf("beat %0d wdata/wstrb %h/%h, expected %h/%h",
					beat, wdata, wstrb, exp_data, exp_strb));
				assert (wlast === (beat == last_beat))
				else report_error($sformatf("wlast %b on beat %0d", wlast, beat));
				beat++;
				cycles = 0;
			end else begin
				cycles++;
				if (cycles > max_wait_cycles) begin
					report_timeout("wvalid");
				end
			end
			wready <= (beat <= last_beat) ? rand_ready(stall) : 1'b0;
		end
		bvalid <= 1'b1;
		cycles = 0;
		done   = 1'b0;
		while (!done) begin
			@(posedge aclk);
			assert (dcache_wr_rdy === 1'b0)
			else report_error("dcache_wr_rdy high before b handshake");
			if (bready && bvalid) begin
				done = 1'b1;
				bvalid <= 1'b0;
			end else begin
				cycles++;
				if (cycles > max_wait_cycles) begin
					report_timeout("bready");
				end
			end
		end
		@(posedge aclk);
		assert (dcache_wr_rdy === 1'b1) else report_error("dcache_wr_rdy low after b handshake");
	endtask

	task automatic test_icache_line_read();
		request_read(1'b0, 32'h0000_1040, 1'b0);
		serve_read(32'h0000_1040, 1'b0, 1'b0, 1'b0);
		@(posedge aclk);
		assert (icache_rd_rdy === 1'b1) else report_error("icache_rd_rdy low after the burst");
	endtask

	task automatic test_uncached_dcache_read();
		request_read(1'b1, 32'h8000_0044, 1'b1);
		serve_read(32'h8000_0044, 1'b1, 1'b1, 1'b0);
		@(posedge aclk);
		assert (dcache_rd_rdy === 1'b1) else report_error("dcache_rd_rdy low after the beat");
	endtask

	task automatic test_read_priority();
		icache_rd_req  <= 1'b1;
		icache_rd_addr <= 32'h0000_3000;
		icache_rd_size <= word_size;
		dcache_rd_req      <= 1'b1;
		dcache_rd_addr     <= 32'h0000_5400;
		dcache_rd_size     <= word_size;
		dcache_rd_uncached <= 1'b0;
		@(posedge aclk);
		assert (dcache_rd_rdy === 1'b1 && icache_rd_rdy === 1'b0)
		else report_error("data cache does not win the read arbitration");
		dcache_rd_req <= 1'b0;   // icache keeps asking
		serve_read(32'h0000_5400, 1'b0, 1'b1, 1'b0);
		request_read(1'b0, 32'h0000_3000, 1'b0);
		serve_read(32'h0000_3000, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic test_line_write();
		logic [`BRIDGE_LINE_W-1:0] line;
		fill_line(line);
		request_write(32'h0000_2000, 4'hf, 1'b0, line, '0);
		serve_write(32'h0000_2000, 4'hf, 1'b0, line, '0, 1'b0);
	endtask

	task automatic test_uncached_write();
		request_write(32'h8000_0102, 4'b1100, 1'b1, '0, 32'hcafe_0000);
		serve_write(32'h8000_0102, 4'b1100, 1'b1, '0, 32'hcafe_0000, 1'b0);
	endtask

	task automatic test_backpressure();
		logic [`BRIDGE_LINE_W-1:0] line;
		fill_line(line);
		request_write(32'h0000_6000, 4'hf, 1'b0, line, '0);
		request_read(1'b1, 32'h0000_7100, 1'b0);
		fork
			serve_write(32'h0000_6000, 4'hf, 1'b0, line, '0, 1'b1);
			serve_read(32'h0000_7100, 1'b0, 1'b1, 1'b1);
		join
	endtask

	initial begin
		seed               = 32'hdb92_a89a;
		aresetn            = 1'b0;
		icache_rd_req      = 1'b0;
		icache_rd_addr     = '0;
		icache_rd_size     = '0;
		dcache_rd_req      = 1'b0;
		dcache_rd_addr     = '0;
		dcache_rd_size     = '0;
		dcache_rd_uncached = 1'b0;
		dcache_wr_req      = 1'b0;
		dcache_wr_addr     = '0;
		dcache_wr_size     = '0;
		dcache_wr_strb     = '0;
		dcache_wr_uncached = 1'b0;
		dcache_wr_line     = '0;
		dcache_wr_word     = '0;
		arready            = 1'b0;
		rdata              = '0;
		rlast              = 1'b0;
		rvalid             = 1'b0;
		awready            = 1'b0;
		wready             = 1'b0;
		bvalid             = 1'b0;
		repeat (8) @(posedge aclk);
		aresetn <= 1'b1;
		@(posedge aclk);
		check_reset_state();
		test_icache_line_read();
		test_uncached_dcache_read();
		test_read_priority();
		test_line_write();
		test_uncached_write();
		test_backpressure();
		repeat (2) @(posedge aclk);
		if (axi_sram_bridge_inst.axi_bridge_assertions_inst.violations == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("%0d AXI protocol assertions failed",
				axi_sram_bridge_inst.axi_bridge_assertions_inst.violations);
			$display("Simulation finished: FAIL");
			$fatal(1, "stopped after AXI protocol assertion failures");
		end
	end

endmodule

// ==== verification/axi_bridge_assertions.sv ====
`timescale 1ns/10ps
`include "axi_bridge_settings.svh"

// AXI master side stability rules of the bridge
module axi_bridge_assertions (
	input logic                      aclk,
	input logic                      aresetn,
	input logic                      arvalid,
	input logic                      arready,
	input logic [`BRIDGE_ADDR_W-1:0] araddr,
	input logic [`BRIDGE_LEN_W-1:0]  arlen,
	input logic                      awvalid,
	input logic                      awready,
	input logic [`BRIDGE_ADDR_W-1:0] awaddr,
	input logic                      wvalid,
	input logic                      wready,
	input logic [`BRIDGE_DATA_W-1:0] wdata,
	input logic                      wlast
);

	int violations = 0;   // failure count seen from the testbench

	ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
	else begin
		violations++;
		$error("ar channel changed before arready");
	end

	aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		awvalid && !awready |=> awvalid && $stable(awaddr))
	else begin
		violations++;
		$error("aw channel changed before awready");
	end

	w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		wvalid && !wready |=> wvalid && $stable(wdata))
	else begin
		violations++;
		$error("w channel changed before wready");
	end

	// no beat follows the accepted last beat
	w_burst_end: assert property (@(posedge aclk) disable iff (!aresetn)
		wvalid && wready && wlast |=> !wvalid)
	else begin
		violations++;
		$error("w beat sent after the last beat");
	end

endmodule

bind axi_sram_bridge axi_bridge_assertions axi_bridge_assertions_inst (
	.aclk   (aclk),
	.aresetn(aresetn),
	.arvalid(arvalid),
	.arready(arready),
	.araddr (araddr),
	.arlen  (arlen),
	.awvalid(awvalid),
	.awready(awready),
	.awaddr (awaddr),
	.wvalid (wvalid),
	.wready (wready),
	.wdata  (wdata),
	.wlast  (wlast)
);

// ==== src/axi_sram_bridge.sv ====
`timescale 1ns/10ps
`include "axi_bridge_settings.svh"

// two cache ports onto one AXI3 master
module axi_sram_bridge (
	input  logic                      aclk,
	input  logic                      aresetn,
	// icache read
	input  logic                      icache_rd_req,
	input  logic [`BRIDGE_ADDR_W-1:0] icache_rd_addr,
	input  logic [`BRIDGE_SIZE_W-1:0] icache_rd_size,
	output logic                      icache_rd_rdy,
	output logic                      icache_ret_valid,
	output logic                      icache_ret_last,
	output logic [`BRIDGE_DATA_W-1:0] icache_ret_data,
	// dcache read
	input  logic                      dcache_rd_req,
	input  logic [`BRIDGE_ADDR_W-1:0] dcache_rd_addr,
	input  logic [`BRIDGE_SIZE_W-1:0] dcache_rd_size,
	input  logic                      dcache_rd_uncached,
	output logic                      dcache_rd_rdy,
	output logic                      dcache_ret_valid,
	output logic                      dcache_ret_last,
	output logic [`BRIDGE_DATA_W-1:0] dcache_ret_data,
	// dcache write
	input  logic                      dcache_wr_req,
	input  logic [`BRIDGE_ADDR_W-1:0] dcache_wr_addr,
	input  logic [`BRIDGE_SIZE_W-1:0] dcache_wr_size,
	input  logic [`BRIDGE_STRB_W-1:0] dcache_wr_strb,
	input  logic                      dcache_wr_uncached,
	input  logic [`BRIDGE_LINE_W-1:0] dcache_wr_line,
	input  logic [`BRIDGE_DATA_W-1:0] dcache_wr_word,
	output logic                      dcache_wr_rdy,
	// AXI read address and data
	output logic [`BRIDGE_ID_W-1:0]   arid,
	output logic [`BRIDGE_ADDR_W-1:0] araddr,
	output logic [`BRIDGE_LEN_W-1:0]  arlen,
	output logic [`BRIDGE_SIZE_W-1:0] arsize,
	output logic [1:0]                arburst,
	output logic                      arvalid,
	input  logic                      arready,
	input  logic [`BRIDGE_DATA_W-1:0] rdata,
	input  logic                      rlast,
	input  logic                      rvalid,
	output logic                      rready,
	// AXI write address, data and response
	output logic [`BRIDGE_ID_W-1:0]   awid,
	output logic [`BRIDGE_ADDR_W-1:0] awaddr,
	output logic [`BRIDGE_LEN_W-1:0]  awlen,
	output logic [`BRIDGE_SIZE_W-1:0] awsize,
	output logic [1:0]                awburst,
	output logic                      awvalid,
	input  logic                      awready,
	output logic [`BRIDGE_ID_W-1:0]   wid,
	output logic [`BRIDGE_DATA_W-1:0] wdata,
	output logic [`BRIDGE_STRB_W-1:0] wstrb,
	output logic                      wlast,
	output logic                      wvalid,
	input  logic                      wready,
	input  logic                      bvalid,
	output logic                      bready
);

	logic rd_accept;
	logic rd_pick_dcache;
	logic in_rd_data;
	logic wr_accept;

	assign rready = 1'b1;   // caches always take read beats

	axi_bridge_ctrl axi_bridge_ctrl_inst (
		.aclk          (aclk),
		.aresetn       (aresetn),
		.icache_rd_req (icache_rd_req),
		.dcache_rd_req (dcache_rd_req),
		.arready       (arready),
		.rvalid        (rvalid),
		.rlast         (rlast),
		.dcache_wr_req (dcache_wr_req),
		.awready       (awready),
		.wready        (wready),
		.wlast         (wlast),
		.bvalid        (bvalid),
		.icache_rd_rdy (icache_rd_rdy),
		.dcache_rd_rdy (dcache_rd_rdy),
		.dcache_wr_rdy (dcache_wr_rdy),
		.rd_accept     (rd_accept),
		.rd_pick_dcache(rd_pick_dcache),
		.arvalid       (arvalid),
		.in_rd_data    (in_rd_data),
		.wr_accept     (wr_accept),
		.awvalid       (awvalid),
		.wvalid        (wvalid),
		.bready        (bready)
	);

	axi_read_port axi_read_port_inst (
		.aclk              (aclk),
		.aresetn           (aresetn),
		.rd_accept         (rd_accept),
		.rd_pick_dcache    (rd_pick_dcache),
		.icache_rd_addr    (icache_rd_addr),
		.icache_rd_size    (icache_rd_size),
		.dcache_rd_addr    (dcache_rd_addr),
		.dcache_rd_size    (dcache_rd_size),
		.dcache_rd_uncached(dcache_rd_uncached),
		.in_rd_data        (in_rd_data),
		.rvalid            (rvalid),
		.rlast             (rlast),
		.rdata             (rdata),
		.araddr            (araddr),
		.arsize            (arsize),
		.arlen             (arlen),
		.arburst           (arburst),
		.arid              (arid),
		.rd_owner_dcache   (),
		.icache_ret_valid  (icache_ret_valid),
		.icache_ret_last   (icache_ret_last),
		.icache_ret_data   (icache_ret_data),
		.dcache_ret_valid  (dcache_ret_valid),
		.dcache_ret_last   (dcache_ret_last),
		.dcache_ret_data   (dcache_ret_data)
	);

	axi_write_port axi_write_port_inst (
		.aclk              (aclk),
		.aresetn           (aresetn),
		.wr_accept         (wr_accept),
		.dcache_wr_addr    (dcache_wr_addr),
		.dcache_wr_size    (dcache_wr_size),
		.dcache_wr_strb    (dcache_wr_strb),
		.dcache_wr_uncached(dcache_wr_uncached),
		.dcache_wr_line    (dcache_wr_line),
		.dcache_wr_word    (dcache_wr_word),
		.wvalid            (wvalid),
		.wready            (wready),
		.awaddr            (awaddr),
		.awsize            (awsize),
		.awlen             (awlen),
		.awburst           (awburst),
		.awid              (awid),
		.wdata             (wdata),
		.wstrb             (wstrb),
		.wlast             (wlast),
		.wid               (wid)
	);

endmodule

// ==== src/axi_write_port.sv ====
`timescale 1ns/10ps
`include "axi_bridge_settings.svh"

module axi_write_port (
	input  logic                      aclk,
	input  logic                      aresetn,
	input  logic                      wr_accept,
	input  logic [`BRIDGE_ADDR_W-1:0] dcache_wr_addr,
	input  logic [`BRIDGE_SIZE_W-1:0] dcache_wr_size,
	input  logic [`BRIDGE_STRB_W-1:0] dcache_wr_strb,
	input  logic                      dcache_wr_uncached,
	input  logic [`BRIDGE_LINE_W-1:0] dcache_wr_line,
	input  logic [`BRIDGE_DATA_W-1:0] dcache_wr_word,
	input  logic                      wvalid,
	input  logic                      wready,
	output logic [`BRIDGE_ADDR_W-1:0] awaddr,
	output logic [`BRIDGE_SIZE_W-1:0] awsize,
	output logic [`BRIDGE_LEN_W-1:0]  awlen,
	output logic [1:0]                awburst,
	output logic [`BRIDGE_ID_W-1:0]   awid,
	output logic [`BRIDGE_DATA_W-1:0] wdata,
	output logic [`BRIDGE_STRB_W-1:0] wstrb,
	output logic                      wlast,
	output logic [`BRIDGE_ID_W-1:0]   wid
);

	axi_bridge_pkg::wr_req_t   wr_next;
	axi_bridge_pkg::wr_req_t   wr_held;
	logic [`BRIDGE_LINE_W-1:0] line_buf;
	logic [`BRIDGE_LEN_W-1:0]  beat_cnt;
	logic                      w_hs;

	assign wr_next.addr     = dcache_wr_addr;
	assign wr_next.size     = dcache_wr_size;
	assign wr_next.strb     = dcache_wr_strb;
	assign wr_next.uncached = dcache_wr_uncached;
	assign wr_next.word     = dcache_wr_word;

	cache_req_latch #(
		.payload_t(axi_bridge_pkg::wr_req_t)
	) wr_req_latch_inst (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.capture   (wr_accept),
		.payload_in(wr_next),
		.held      (wr_held)
	);

	assign w_hs = wvalid & wready;

	// lowest word goes out first
	always_ff @(posedge aclk) begin
		if (wr_accept) begin
			line_buf <= dcache_wr_line;
		end else if (w_hs) begin
			line_buf <= {{`BRIDGE_DATA_W{1'b0}}, line_buf[`BRIDGE_LINE_W-1:`BRIDGE_DATA_W]};
		end
	end

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			beat_cnt <= '0;
		end else if (wr_accept) begin
			beat_cnt <= '0;   // fresh burst
		end else if (w_hs) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	assign awaddr  = wr_held.addr;
	assign awsize  = wr_held.size;
	assign awlen   = wr_held.uncached ? '0 : `BRIDGE_LEN_W'(`BRIDGE_LINE_BEATS - 1);
	assign awburst = wr_held.uncached ? `BRIDGE_BURST_FIXED : `BRIDGE_BURST_INCR;
	assign awid    = `BRIDGE_DCACHE_ID;
	assign wid     = `BRIDGE_DCACHE_ID;

	assign wdata = wr_held.uncached ? wr_held.word : line_buf[`BRIDGE_DATA_W-1:0];
	assign wstrb = wr_held.strb;

	// uncached stores are one beat long
	assign wlast = wvalid &
		(wr_held.uncached | (beat_cnt == `BRIDGE_LEN_W'(`BRIDGE_LINE_BEATS - 1)));

endmodule

// ==== src/axi_read_port.sv ====
`timescale 1ns/10ps
`include "axi_bridge_settings.svh"

module axi_read_port (
	input  logic                      aclk,
	input  logic                      aresetn,
	input  logic                      rd_accept,
	input  logic                      rd_pick_dcache,
	input  logic [`BRIDGE_ADDR_W-1:0] icache_rd_addr,
	input  logic [`BRIDGE_SIZE_W-1:0] icache_rd_size,
	input  logic [`BRIDGE_ADDR_W-1:0] dcache_rd_addr,
	input  logic [`BRIDGE_SIZE_W-1:0] dcache_rd_size,
	input  logic                      dcache_rd_uncached,
	input  logic                      in_rd_data,
	input  logic                      rvalid,
	input  logic                      rlast,
	input  logic [`BRIDGE_DATA_W-1:0] rdata,
	output logic [`BRIDGE_ADDR_W-1:0] araddr,
	output logic [`BRIDGE_SIZE_W-1:0] arsize,
	output logic [`BRIDGE_LEN_W-1:0]  arlen,
	output logic [1:0]                arburst,
	output logic [`BRIDGE_ID_W-1:0]   arid,
	output logic                      rd_owner_dcache,
	output logic                      icache_ret_valid,
	output logic                      icache_ret_last,
	output logic [`BRIDGE_DATA_W-1:0] icache_ret_data,
	output logic                      dcache_ret_valid,
	output logic                      dcache_ret_last,
	output logic [`BRIDGE_DATA_W-1:0] dcache_ret_data
);

	axi_bridge_pkg::rd_req_t rd_next;
	axi_bridge_pkg::rd_req_t rd_held;
	logic                    beat;

	// granted request, icache reads are always line fills
	always_comb begin
		if (rd_pick_dcache) begin
			rd_next.addr        = dcache_rd_addr;
			rd_next.size        = dcache_rd_size;
			rd_next.uncached    = dcache_rd_uncached;
			rd_next.from_dcache = 1'b1;
		end else begin
			rd_next.addr        = icache_rd_addr;
			rd_next.size        = icache_rd_size;
			rd_next.uncached    = 1'b0;
			rd_next.from_dcache = 1'b0;
		end
	end

	cache_req_latch #(
		.payload_t(axi_bridge_pkg::rd_req_t)
	) rd_req_latch_inst (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.capture   (rd_accept),
		.payload_in(rd_next),
		.held      (rd_held)
	);

	assign araddr  = rd_held.addr;
	assign arsize  = rd_held.size;
	assign arlen   = rd_held.uncached ? '0 : `BRIDGE_LEN_W'(`BRIDGE_LINE_BEATS - 1);
	assign arburst = rd_held.uncached ? `BRIDGE_BURST_FIXED : `BRIDGE_BURST_INCR;
	assign arid    = rd_held.from_dcache ? `BRIDGE_DCACHE_ID : `BRIDGE_ICACHE_ID;

	assign rd_owner_dcache = rd_held.from_dcache;

	// only the owner sees valid and last
	assign beat = in_rd_data & rvalid;

	assign icache_ret_valid = beat & ~rd_held.from_dcache;
	assign icache_ret_last  = beat & rlast & ~rd_held.from_dcache;
	assign icache_ret_data  = rdata;

	assign dcache_ret_valid = beat & rd_held.from_dcache;
	assign dcache_ret_last  = beat & rlast & rd_held.from_dcache;
	assign dcache_ret_data  = rdata;

endmodule

// ==== src/axi_bridge_ctrl.sv ====
`timescale 1ns/10ps

module axi_bridge_ctrl (
	input  logic aclk,
	input  logic aresetn,
	input  logic icache_rd_req,
	input  logic dcache_rd_req,
	input  logic arready,
	input  logic rvalid,
	input  logic rlast,
	input  logic dcache_wr_req,
	input  logic awready,
	input  logic wready,
	input  logic wlast,
	input  logic bvalid,
	output logic icache_rd_rdy,
	output logic dcache_rd_rdy,
	output logic dcache_wr_rdy,
	output logic rd_accept,
	output logic rd_pick_dcache,
	output logic arvalid,
	output logic in_rd_data,
	output logic wr_accept,
	output logic awvalid,
	output logic wvalid,
	output logic bready
);

	axi_bridge_pkg::rd_state_e rd_state;
	axi_bridge_pkg::wr_state_e wr_state;

	// read side, dcache has priority over icache
	assign dcache_rd_rdy  = (rd_state == axi_bridge_pkg::rd_idle);
	assign icache_rd_rdy  = (rd_state == axi_bridge_pkg::rd_idle) & ~dcache_rd_req;
	assign rd_pick_dcache = dcache_rd_req & dcache_rd_rdy;
	assign rd_accept      = rd_pick_dcache | (icache_rd_req & icache_rd_rdy);

	assign arvalid    = (rd_state == axi_bridge_pkg::rd_addr);
	assign in_rd_data = (rd_state == axi_bridge_pkg::rd_data);

	// rready is tied high, so rvalid alone is a handshake
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			rd_state <= axi_bridge_pkg::rd_idle;
		end else begin
			case (rd_state)
				axi_bridge_pkg::rd_idle: begin
					if (rd_accept) begin
						rd_state <= axi_bridge_pkg::rd_addr;
					end
				end
				axi_bridge_pkg::rd_addr: begin
					if (arready) begin
						rd_state <= axi_bridge_pkg::rd_data;
					end
				end
				axi_bridge_pkg::rd_data: begin
					if (rvalid & rlast) begin
						rd_state <= axi_bridge_pkg::rd_idle;
					end
				end
				default: rd_state <= axi_bridge_pkg::rd_idle;
			endcase
		end
	end

	// write side
	assign dcache_wr_rdy = (wr_state == axi_bridge_pkg::wr_idle);
	assign wr_accept     = dcache_wr_req & dcache_wr_rdy;
	assign awvalid       = (wr_state == axi_bridge_pkg::wr_addr);
	assign wvalid        = (wr_state == axi_bridge_pkg::wr_data);
	assign bready        = (wr_state == axi_bridge_pkg::wr_resp);

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			wr_state <= axi_bridge_pkg::wr_idle;
		end else begin
			case (wr_state)
				axi_bridge_pkg::wr_idle: begin
					if (wr_accept) begin
						wr_state <= axi_bridge_pkg::wr_addr;
					end
				end
				axi_bridge_pkg::wr_addr: begin
					if (awready) begin
						wr_state <= axi_bridge_pkg::wr_data;
					end
				end
				axi_bridge_pkg::wr_data: begin
					if (wready & wlast) begin   // last beat accepted
						wr_state <= axi_bridge_pkg::wr_resp;
					end
				end
				axi_bridge_pkg::wr_resp: begin
					if (bvalid) begin
						wr_state <= axi_bridge_pkg::wr_idle;
					end
				end
				default: wr_state <= axi_bridge_pkg::wr_idle;
			endcase
		end
	end

endmodule

// ==== src/cache_req_latch.sv ====
`timescale 1ns/10ps

// holds one cache request for the whole AXI transaction
module cache_req_latch #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     aclk,
	input  logic     aresetn,
	input  logic     capture,     // accept strobe from the controller
	input  payload_t payload_in,
	output payload_t held
);

	payload_t held_q;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			held_q <= '0;
		end else if (capture) begin
			held_q <= payload_in;   // valid from the next cycle on
		end
	end

	assign held = held_q;

endmodule

// ==== src/axi_bridge_pkg.sv ====
`include "axi_bridge_settings.svh"

package axi_bridge_pkg;

	// latched read request, one per read in flight
	typedef struct packed {
		logic [`BRIDGE_ADDR_W-1:0] addr;
		logic [`BRIDGE_SIZE_W-1:0] size;
		logic                      uncached;     // single beat when set
		logic                      from_dcache;  // owner of the returned beats
	} rd_req_t;

	// latched write request
	// the line itself sits in the shift buffer of the write port
	typedef struct packed {
		logic [`BRIDGE_ADDR_W-1:0] addr;
		logic [`BRIDGE_SIZE_W-1:0] size;
		logic [`BRIDGE_STRB_W-1:0] strb;
		logic                      uncached;
		logic [`BRIDGE_DATA_W-1:0] word;  // payload of an uncached store
	} wr_req_t;

	typedef enum logic [1:0] {
		rd_idle,
		rd_addr,   // ar channel pending
		rd_data    // beats coming back
	} rd_state_e;

	typedef enum logic [1:0] {
		wr_idle,
		wr_addr,   // aw channel pending
		wr_data,   // w beats going out
		wr_resp    // waiting on b channel
	} wr_state_e;

endpackage

// ==== src/axi_bridge_settings.svh ====
`ifndef AXI_BRIDGE_SETTINGS_SVH
`define AXI_BRIDGE_SETTINGS_SVH

// bus and line geometry
`define BRIDGE_ADDR_W      32
`define BRIDGE_DATA_W      32
`define BRIDGE_LINE_BEATS  16
`define BRIDGE_LINE_W      512   // 16 words of 32 bits
`define BRIDGE_STRB_W      4

// AXI3 field widths
`define BRIDGE_ID_W        4
`define BRIDGE_LEN_W       4
`define BRIDGE_SIZE_W      3

// burst codes, 2 bit field
`define BRIDGE_BURST_INCR  2'b01
`define BRIDGE_BURST_FIXED 2'b00   // single beat accesses only

// transaction ids
`define BRIDGE_ICACHE_ID   4'd0
`define BRIDGE_DCACHE_ID   4'd1   // shared by dcache reads and writes

`endif
